/* fixed_pkg.sv */
package fixed_pkg;

    // operands and results are unsigned and the reciprocal is a pure fraction
    localparam int DATA_W   = 24;
    localparam int NUM_ITER = 4;
    localparam int FRAC_W   = DATA_W;

    typedef struct packed {
        logic [DATA_W-1:0] divisor;
        logic [DATA_W-1:0] dividend;
    } div_req_t;

    // dividend rides along with the reciprocal so the multiplier needs no side channel
    typedef struct packed {
        logic [DATA_W-1:0] recip;
        logic [DATA_W-1:0] dividend;
        logic              div_zero;
    } recip_res_t;

    typedef struct packed {
        logic [DATA_W-1:0] recip;
        logic [DATA_W-1:0] quot;
        logic              div_zero;
    } div_res_t;

endpackage

/* axil_pkg.sv */
package axil_pkg;

    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL     = 8'h00;
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS   = 8'h04;
    localparam logic [AXIL_ADDR_W-1:0] REG_DIVISOR  = 8'h08;
    localparam logic [AXIL_ADDR_W-1:0] REG_DIVIDEND = 8'h0C;
    localparam logic [AXIL_ADDR_W-1:0] REG_RECIP    = 8'h10;
    localparam logic [AXIL_ADDR_W-1:0] REG_QUOT     = 8'h14;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   awvalid;
        logic [AXIL_DATA_W-1:0] wdata;
        logic                   wvalid;
        logic                   bready;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic [1:0]             bresp;
        logic                   bvalid;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axil_rsp_t;

endpackage

/* axil_regs.sv */
`timescale 1ns/10ps

module axil_regs (
    input  logic                clk,
    input  logic                rstn,
    input  axil_pkg::axil_req_t axil_req,
    output axil_pkg::axil_rsp_t axil_rsp,
    output fixed_pkg::div_req_t req,
    output logic                start,
    input  logic                ready,
    input  fixed_pkg::div_res_t res,
    input  logic                res_valid,
    output logic                irq
);
    import axil_pkg::*;
    import fixed_pkg::*;

    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic                   arready;
    logic                   rvalid;
    logic [1:0]             bresp;
    logic [1:0]             rresp;
    logic [AXIL_DATA_W-1:0] rdata;

    logic                   aw_held;
    logic                   w_held;
    logic [AXIL_ADDR_W-1:0] aw_addr_q;
    logic [AXIL_DATA_W-1:0] w_data_q;

    logic                   busy;
    logic                   done;
    logic                   div_zero;
    logic [DATA_W-1:0]      recip_q;
    logic [DATA_W-1:0]      quot_q;

    logic                   aw_hs;
    logic                   w_hs;
    logic                   ar_hs;
    logic                   wr_go;
    logic                   aw_held_n;
    logic                   w_held_n;
    logic                   bvalid_n;
    logic                   rvalid_n;
    logic                   launch;
    logic [AXIL_ADDR_W-1:0] wr_word;
    logic [AXIL_DATA_W-1:0] wr_data;
    logic [1:0]             wr_resp;
    logic [AXIL_DATA_W-1:0] rd_data;
    logic [1:0]             rd_resp;

    // AW and W are taken independently and the write executes once both are in hand
    always_comb begin
        aw_hs     = axil_req.awvalid & awready;
        w_hs      = axil_req.wvalid & wready;
        ar_hs     = axil_req.arvalid & arready;
        wr_go     = (aw_held | aw_hs) & (w_held | w_hs);
        aw_held_n = (aw_held | aw_hs) & ~wr_go;
        w_held_n  = (w_held | w_hs) & ~wr_go;
        bvalid_n  = (bvalid & ~axil_req.bready) | wr_go;
        rvalid_n  = (rvalid & ~axil_req.rready) | ar_hs;
        wr_word   = aw_held ? aw_addr_q : axil_req.awaddr;
        wr_word   = {wr_word[AXIL_ADDR_W-1:2], 2'b00};
        wr_data   = w_held ? w_data_q : axil_req.wdata;
    end

    always_comb begin
        wr_resp = RESP_OKAY;
        case (wr_word)
            REG_CTRL: begin
                if (wr_data[0] && (busy || !ready)) begin
                    wr_resp = RESP_SLVERR;
                end
            end
            REG_DIVISOR, REG_DIVIDEND: begin
                wr_resp = RESP_OKAY;
            end
            default: begin
                wr_resp = RESP_SLVERR;
            end
        endcase
        launch = wr_go && (wr_word == REG_CTRL) && wr_data[0] && !busy && ready;
    end

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case ({axil_req.araddr[AXIL_ADDR_W-1:2], 2'b00})
            // the start bit clears itself
            REG_CTRL:     rd_data = '0;
            REG_STATUS:   rd_data = AXIL_DATA_W'({div_zero, done, busy});
            REG_DIVISOR:  rd_data = AXIL_DATA_W'(req.divisor);
            REG_DIVIDEND: rd_data = AXIL_DATA_W'(req.dividend);
            REG_RECIP:    rd_data = AXIL_DATA_W'(recip_q);
            REG_QUOT:     rd_data = AXIL_DATA_W'(quot_q);
            default:      rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            arready  <= 1'b0;
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            start    <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            div_zero <= 1'b0;
            req      <= '0;
            recip_q  <= '0;
            quot_q   <= '0;
        end else begin
            // a pending response holds off the next request on its path
            awready <= ~aw_held_n & ~bvalid_n;
            wready  <= ~w_held_n & ~bvalid_n;
            arready <= ~rvalid_n;
            aw_held <= aw_held_n;
            w_held  <= w_held_n;
            bvalid  <= bvalid_n;
            rvalid  <= rvalid_n;
            start   <= launch;
            if (res_valid) begin
                recip_q  <= res.recip;
                quot_q   <= res.quot;
                div_zero <= res.div_zero;
                busy     <= 1'b0;
                done     <= 1'b1;
            end
            if (launch) begin
                busy     <= 1'b1;
                done     <= 1'b0;
                div_zero <= 1'b0;
            end
            if (wr_go && wr_word == REG_DIVISOR) begin
                req.divisor <= wr_data[DATA_W-1:0];
            end
            if (wr_go && wr_word == REG_DIVIDEND) begin
                req.dividend <= wr_data[DATA_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= axil_req.awaddr;
        end
        if (w_hs) begin
            w_data_q <= axil_req.wdata;
        end
        if (wr_go) begin
            bresp <= wr_resp;
        end
        if (ar_hs) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    always_comb begin
        axil_rsp.awready = awready;
        axil_rsp.wready  = wready;
        axil_rsp.bresp   = bresp;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.arready = arready;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
        axil_rsp.rvalid  = rvalid;
    end

    assign irq = done;

    a_bvalid_held: assert property (@(posedge clk) disable iff (!rstn)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp));

    // the reciprocal unit has no input buffer, so a start it is not ready for is lost
    a_start_ready: assert property (@(posedge clk) disable iff (!rstn)
        start |-> ready);

endmodule

/* newton_recip.sv */
`timescale 1ns/10ps

module newton_recip (
    input  logic                   clk,
    input  logic                   rstn,
    output logic                   ready,
    input  fixed_pkg::div_req_t    req,
    input  logic                   start,
    output fixed_pkg::recip_res_t  rec,
    output logic                   rec_valid
);
    import fixed_pkg::*;

    localparam int W2      = 2 * DATA_W;
    localparam int PROD_W  = W2 + 2;
    localparam int SHIFT_W = $clog2(DATA_W) + 1;
    localparam int ITER_W  = $clog2(NUM_ITER) + 1;
    localparam logic [W2-1:0] ONE = W2'(1) << FRAC_W;
    localparam logic [W2-1:0] TWO = W2'(2) << FRAC_W;

    typedef enum logic [1:0] {
        IDLE,
        PREPROCESS,
        PROCESS,
        POSTPROCESS
    } state_t;

    state_t              state;
    logic [ITER_W-1:0]   iter;
    logic [W2-1:0]       a_q;
    logic [W2-1:0]       a_scaled;
    logic [W2-1:0]       x;
    logic [SHIFT_W-1:0]  shift_q;
    logic [DATA_W-1:0]   dividend_q;
    logic                div_zero_q;

    logic [SHIFT_W-1:0]  shift_w;
    logic [PROD_W-1:0]   ax_prod;
    logic [PROD_W-1:0]   xn_prod;
    logic [W2-1:0]       ax;
    logic [W2-1:0]       two_minus_ax;
    logic [W2-1:0]       x_next;

    // shift by one past the leading one, which puts the divisor in [0.5, 1)
    always_comb begin
        shift_w = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (a_q[i+DATA_W]) begin
                shift_w = SHIFT_W'(i + 1);
            end
        end
    end

    // one Newton step with each product cut back to FRAC_W fraction bits
    always_comb begin
        ax_prod      = PROD_W'(a_scaled) * PROD_W'(x);
        ax           = W2'(ax_prod >> FRAC_W);
        two_minus_ax = TWO - ax;
        xn_prod      = PROD_W'(x) * PROD_W'(two_minus_ax);
        x_next       = W2'(xn_prod >> FRAC_W);
    end

    assign ready = (state == IDLE);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= IDLE;
            iter      <= '0;
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= 1'b0;
            case (state)
                IDLE: begin
                    iter <= '0;
                    if (start) begin
                        state <= PREPROCESS;
                    end
                end
                PREPROCESS: begin
                    state <= PROCESS;
                end
                PROCESS: begin
                    iter <= iter + 1'b1;
                    if (iter == ITER_W'(NUM_ITER - 1)) begin
                        state <= POSTPROCESS;
                    end
                end
                POSTPROCESS: begin
                    rec_valid <= 1'b1;
                    state     <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                x <= ONE;
                if (start) begin
                    a_q        <= {req.divisor, {DATA_W{1'b0}}};
                    dividend_q <= req.dividend;
                end
            end
            PREPROCESS: begin
                shift_q    <= shift_w;
                a_scaled   <= a_q >> shift_w;
                div_zero_q <= ~|a_q;
            end
            PROCESS: begin
                x <= x_next;
            end
            POSTPROCESS: begin
                rec.recip    <= div_zero_q ? {DATA_W{1'b1}} : DATA_W'(x >> shift_q);
                rec.dividend <= dividend_q;
                rec.div_zero <= div_zero_q;
            end
            default: begin
                x <= ONE;
            end
        endcase
    end

    a_rec_valid_pulse: assert property (@(posedge clk) disable iff (!rstn)
        rec_valid |=> !rec_valid);

endmodule

/* quotient_mul.sv */
`timescale 1ns/10ps

module quotient_mul (
    input  logic                  clk,
    input  logic                  rstn,
    input  fixed_pkg::recip_res_t rec,
    input  logic                  rec_valid,
    output fixed_pkg::div_res_t   res,
    output logic                  res_valid
);
    import fixed_pkg::*;

    logic [2*DATA_W-1:0] prod_q;
    logic [DATA_W-1:0]   recip_s1;
    logic                div_zero_s1;
    logic                valid_s1;

    logic [2*DATA_W-1:0] quot_full;
    logic [DATA_W-1:0]   quot_sat;

    always_comb begin
        quot_full = prod_q >> FRAC_W;
        quot_sat  = |quot_full[2*DATA_W-1:DATA_W] ? {DATA_W{1'b1}} : quot_full[DATA_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_s1  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            valid_s1  <= rec_valid;
            res_valid <= valid_s1;
        end
    end

    always_ff @(posedge clk) begin
        prod_q      <= (2*DATA_W)'(rec.dividend) * (2*DATA_W)'(rec.recip);
        recip_s1    <= rec.recip;
        div_zero_s1 <= rec.div_zero;

        res.recip    <= recip_s1;
        res.quot     <= div_zero_s1 ? {DATA_W{1'b1}} : quot_sat;
        res.div_zero <= div_zero_s1;
    end

endmodule

/* recip_div_top.sv */
`timescale 1ns/10ps

module recip_div_top (
    input  logic                clk,
    input  logic                rstn,
    input  axil_pkg::axil_req_t axil_req,
    output axil_pkg::axil_rsp_t axil_rsp,
    output logic                irq
);
    import fixed_pkg::*;

    div_req_t   req;
    logic       start;
    logic       ready;
    recip_res_t rec;
    logic       rec_valid;
    div_res_t   res;
    logic       res_valid;

    axil_regs i_axil_regs (
        .clk       (clk),
        .rstn      (rstn),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .req       (req),
        .start     (start),
        .ready     (ready),
        .res       (res),
        .res_valid (res_valid),
        .irq       (irq)
    );

    newton_recip i_newton_recip (
        .clk       (clk),
        .rstn      (rstn),
        .ready     (ready),
        .req       (req),
        .start     (start),
        .rec       (rec),
        .rec_valid (rec_valid)
    );

    quotient_mul i_quotient_mul (
        .clk       (clk),
        .rstn      (rstn),
        .rec       (rec),
        .rec_valid (rec_valid),
        .res       (res),
        .res_valid (res_valid)
    );

    // reciprocal unit plus the two multiplier stages give a fixed start to result delay
    a_div_latency: assert property (@(posedge clk) disable iff (!rstn)
        start |-> ##(NUM_ITER + 5) res_valid);

endmodule

/* tb_recip_div.sv */
`timescale 1ns/10ps

module tb_recip_div;
    import axil_pkg::*;
    import fixed_pkg::*;

    localparam int          CLK_HALF   = 5;
    localparam int          RST_CYCLES = 16;
    localparam int          DRIVE_DLY  = 1;
    localparam logic [31:0] SEED       = 32'h5752558b;
    localparam string       PAT_FILE   = "recip_div_patterns.txt";

    typedef struct packed {
        logic [DATA_W-1:0] divisor;
        logic [DATA_W-1:0] dividend;
        logic [DATA_W-1:0] recip;
        logic [DATA_W-1:0] quot;
        logic              div_zero;
    } pattern_t;

    logic      clk;
    logic      rstn;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    logic      irq;

    pattern_t pats[$];
    int       err_cnt;
    int       fail_cnt;
    bit       loaded;
    bit       gaps_on;

    recip_div_top i_recip_div_top (
        .clk      (clk),
        .rstn     (rstn),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .irq      (irq)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // all driving happens a little after the rising edge and outputs are read there too
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    function automatic int pick_gap();
        if (gaps_on) begin
            return $urandom % 4;
        end
        return 0;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        err_cnt++;
    endtask

    task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr,
                              input logic [AXIL_DATA_W-1:0] data,
                              output logic [1:0] resp);
        int aw_gap;
        int w_gap;
        int b_gap;
        aw_gap = pick_gap();
        w_gap  = pick_gap();
        b_gap  = pick_gap();
        fork
            begin
                idle_cycles(aw_gap);
                axil_req.awaddr  = addr;
                axil_req.awvalid = 1'b1;
                while (!axil_rsp.awready) next_cycle();
                next_cycle();
                axil_req.awvalid = 1'b0;
            end
            begin
                idle_cycles(w_gap);
                axil_req.wdata  = data;
                axil_req.wvalid = 1'b1;
                while (!axil_rsp.wready) next_cycle();
                next_cycle();
                axil_req.wvalid = 1'b0;
            end
        join
        idle_cycles(b_gap);
        axil_req.bready = 1'b1;
        while (!axil_rsp.bvalid) next_cycle();
        resp = axil_rsp.bresp;
        next_cycle();
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr,
                             output logic [AXIL_DATA_W-1:0] data,
                             output logic [1:0] resp);
        int ar_gap;
        int r_gap;
        ar_gap = pick_gap();
        r_gap  = pick_gap();
        idle_cycles(ar_gap);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        while (!axil_rsp.arready) next_cycle();
        next_cycle();
        axil_req.arvalid = 1'b0;
        idle_cycles(r_gap);
        axil_req.rready = 1'b1;
        while (!axil_rsp.rvalid) next_cycle();
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        next_cycle();
        axil_req.rready = 1'b0;
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_div;
        logic [31:0] f_dvd;
        logic [31:0] f_rcp;
        logic [31:0] f_quo;
        logic [31:0] f_dz;
        pattern_t    p;
        fd = $fopen(PAT_FILE, "r");
        if (fd == 0) begin
            $display("could not open the pattern file %s", PAT_FILE);
            fail_cnt++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h", f_div, f_dvd, f_rcp, f_quo, f_dz);
                    if (n == 5) begin
                        p.divisor  = f_div[DATA_W-1:0];
                        p.dividend = f_dvd[DATA_W-1:0];
                        p.recip    = f_rcp[DATA_W-1:0];
                        p.quot     = f_quo[DATA_W-1:0];
                        p.div_zero = f_dz[0];
                        pats.push_back(p);
                    end else begin
                        $display("a pattern line could not be read: %s", line);
                        fail_cnt++;
                    end
                end
            end
            $fclose(fd);
            if (pats.size() == 0) begin
                $display("the pattern file holds no test lines");
                fail_cnt++;
            end
        end
    endtask

    task automatic start_division(input pattern_t p, input int idx);
        logic [1:0] resp;
        axil_write(REG_DIVISOR, {8'h00, p.divisor}, resp);
        if (resp !== RESP_OKAY) report_mismatch($sformatf("test %0d DIVISOR bresp", idx),
                                                32'(resp), 32'(RESP_OKAY));
        axil_write(REG_DIVIDEND, {8'h00, p.dividend}, resp);
        if (resp !== RESP_OKAY) report_mismatch($sformatf("test %0d DIVIDEND bresp", idx),
                                                32'(resp), 32'(RESP_OKAY));
        axil_write(REG_CTRL, 32'h1, resp);
        if (resp !== RESP_OKAY) report_mismatch($sformatf("test %0d CTRL bresp", idx),
                                                32'(resp), 32'(RESP_OKAY));
    endtask

    task automatic wait_done(output logic [31:0] status);
        logic [1:0] resp;
        status = '0;
        while (!status[1]) begin
            axil_read(REG_STATUS, status, resp);
            if (resp !== RESP_OKAY) report_mismatch("STATUS rresp", 32'(resp), 32'(RESP_OKAY));
        end
    endtask

    task automatic check_results(input pattern_t p, input int idx, input logic [31:0] status);
        logic [31:0] rdata;
        logic [1:0]  resp;
        if (irq !== 1'b1) report_mismatch($sformatf("test %0d irq when done", idx),
                                          32'(irq), 32'h1);
        if (status !== {29'd0, p.div_zero, 2'b10}) begin
            report_mismatch($sformatf("test %0d STATUS", idx), status,
                            {29'd0, p.div_zero, 2'b10});
        end
        axil_read(REG_RECIP, rdata, resp);
        if (resp !== RESP_OKAY) report_mismatch($sformatf("test %0d RECIP rresp", idx),
                                                32'(resp), 32'(RESP_OKAY));
        if (rdata !== {8'h00, p.recip}) report_mismatch($sformatf("test %0d RECIP", idx),
                                                        rdata, {8'h00, p.recip});
        axil_read(REG_QUOT, rdata, resp);
        if (resp !== RESP_OKAY) report_mismatch($sformatf("test %0d QUOT rresp", idx),
                                                32'(resp), 32'(RESP_OKAY));
        if (rdata !== {8'h00, p.quot}) report_mismatch($sformatf("test %0d QUOT", idx),
                                                       rdata, {8'h00, p.quot});
    endtask

    task automatic check_reset_state();
        logic [31:0] rdata;
        logic [1:0]  resp;
        if (irq !== 1'b0) report_mismatch("irq after reset", 32'(irq), 32'h0);
        axil_read(REG_STATUS, rdata, resp);
        if (resp !== RESP_OKAY || rdata !== 32'h0) report_mismatch("STATUS after reset",
                                                                   rdata, 32'h0);
        axil_read(REG_RECIP, rdata, resp);
        if (resp !== RESP_OKAY || rdata !== 32'h0) report_mismatch("RECIP after reset",
                                                                   rdata, 32'h0);
        axil_read(REG_QUOT, rdata, resp);
        if (resp !== RESP_OKAY || rdata !== 32'h0) report_mismatch("QUOT after reset",
                                                                   rdata, 32'h0);
    endtask

    task automatic run_pattern(input pattern_t p, input int idx);
        logic [31:0] status;
        start_division(p, idx);
        // a new start clears done long before the result can come back
        if (irq !== 1'b0) report_mismatch($sformatf("test %0d irq after start", idx),
                                          32'(irq), 32'h0);
        wait_done(status);
        check_results(p, idx, status);
    endtask

    task automatic check_start_while_busy(input pattern_t p);
        logic [31:0] status;
        logic [1:0]  resp;
        gaps_on = 1'b0;
        start_division(p, -1);
        axil_write(REG_CTRL, 32'h1, resp);
        gaps_on = 1'b1;
        if (resp !== RESP_SLVERR) report_mismatch("second start bresp", 32'(resp),
                                                  32'(RESP_SLVERR));
        wait_done(status);
        check_results(p, -1, status);
    endtask

    task automatic check_illegal_access(input pattern_t p);
        logic [31:0] rdata;
        logic [1:0]  resp;
        axil_write(REG_RECIP, 32'h00ABCDEF, resp);
        if (resp !== RESP_SLVERR) report_mismatch("RECIP write bresp", 32'(resp),
                                                  32'(RESP_SLVERR));
        axil_read(REG_RECIP, rdata, resp);
        if (rdata !== {8'h00, p.recip}) report_mismatch("RECIP after write", rdata,
                                                        {8'h00, p.recip});
        axil_read(8'h20, rdata, resp);
        if (resp !== RESP_SLVERR) report_mismatch("unmapped read rresp", 32'(resp),
                                                  32'(RESP_SLVERR));
        if (rdata !== 32'h0) report_mismatch("unmapped read data", rdata, 32'h0);
    endtask

    task automatic finish_run();
        $display("errors: %0d wrong values, %0d other failures", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    initial begin
        int limit;
        wait (loaded);
        limit = pats.size() * 200 + 1000;
        repeat (limit) @(posedge clk);
        $display("timeout: the test did not finish within %0d cycles", limit);
        fail_cnt++;
        finish_run();
    end

    initial begin
        void'($urandom(SEED));
        err_cnt  = 0;
        fail_cnt = 0;
        gaps_on  = 1'b1;
        rstn     = 1'b0;
        axil_req = '0;
        load_patterns();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rstn = 1'b1;
        next_cycle();
        check_reset_state();
        foreach (pats[i]) begin
            run_pattern(pats[i], i);
        end
        if (pats.size() > 0) begin
            check_start_while_busy(pats[0]);
            check_illegal_access(pats[0]);
        end
        finish_run();
    end

endmodule

/* recip_div.f */
fixed_pkg.sv
axil_pkg.sv
axil_regs.sv
newton_recip.sv
quotient_mul.sv
recip_div_top.sv
tb_recip_div.sv

/* Makefile */
SIM        := verilator
TOP        := tb_recip_div
FILELIST   := recip_div.f
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
SIM_BIN    := obj_dir/V$(TOP)
PASS_MSG   := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only if the pass line shows up in the simulator output
sim:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(SIM_BIN) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* recip_div_patterns.txt */
# columns in hex: divisor dividend expected_recip expected_quot expected_div_zero
# recip and quot come from four truncating Newton steps, quot drops 24 fraction bits
000001 FFFFFF FFFF00 FFFEFF 0
000001 000064 FFFF00 000063 0
000002 000100 7FFF80 00007F 0
000002 FFFFFF 7FFF80 7FFF7F 0
000010 123456 0FFFF0 012344 0
001000 ABCDEF 000FFF 000ABC 0
800000 FFFFFF 000001 000000 0
000003 000009 555555 000002 0
000003 FFFFFF 555555 555554 0
000006 600000 2AAAAA 0FFFFF 0
00000C 000C00 155555 0000FF 0
300000 900000 000005 000002 0
C00000 FFFFFF 000001 000000 0
000005 00000A 333332 000001 0
000005 7FFFFF 333332 199998 0
00000A 000064 199999 000009 0
000050 123456 033333 003A41 0
500000 FFFFFF 000003 000002 0
FFFFFF FFFFFF 000001 000000 0
FFFFFF 000000 000001 000000 0
000000 123456 FFFFFF FFFFFF 1
000003 000000 555555 000000 0
000000 000000 FFFFFF FFFFFF 1
